//--- common/mipsCtrlPkg.sv
package mipsCtrlPkg;

   // primary opcodes, instr[31:26]
   localparam logic [5:0] opRtype  = 6'h00;
   localparam logic [5:0] opRegimm = 6'h01;
   localparam logic [5:0] opJ      = 6'h02;
   localparam logic [5:0] opJal    = 6'h03;
   localparam logic [5:0] opBeq    = 6'h04;
   localparam logic [5:0] opBne    = 6'h05;
   localparam logic [5:0] opBlez   = 6'h06;
   localparam logic [5:0] opBgtz   = 6'h07;
   localparam logic [5:0] opAddiu  = 6'h09;
   localparam logic [5:0] opSlti   = 6'h0a;
   localparam logic [5:0] opSltiu  = 6'h0b;
   localparam logic [5:0] opAndi   = 6'h0c;
   localparam logic [5:0] opOri    = 6'h0d;
   localparam logic [5:0] opXori   = 6'h0e;
   localparam logic [5:0] opLui    = 6'h0f;
   localparam logic [5:0] opCop0   = 6'h10;
   localparam logic [5:0] opLb     = 6'h20;
   localparam logic [5:0] opLh     = 6'h21;
   localparam logic [5:0] opLw     = 6'h23;
   localparam logic [5:0] opLbu    = 6'h24;
   localparam logic [5:0] opLhu    = 6'h25;
   localparam logic [5:0] opSb     = 6'h28;
   localparam logic [5:0] opSh     = 6'h29;
   localparam logic [5:0] opSw     = 6'h2b;

   // R-type function codes, instr[5:0]
   localparam logic [5:0] fnSll  = 6'h00;
   localparam logic [5:0] fnSrl  = 6'h02;
   localparam logic [5:0] fnSra  = 6'h03;
   localparam logic [5:0] fnSllv = 6'h04;
   localparam logic [5:0] fnSrlv = 6'h06;
   localparam logic [5:0] fnSrav = 6'h07;
   localparam logic [5:0] fnJr   = 6'h08;
   localparam logic [5:0] fnJalr = 6'h09;
   localparam logic [5:0] fnAddu = 6'h21;
   localparam logic [5:0] fnSubu = 6'h23;
   localparam logic [5:0] fnAnd  = 6'h24;
   localparam logic [5:0] fnOr   = 6'h25;
   localparam logic [5:0] fnXor  = 6'h26;
   localparam logic [5:0] fnNor  = 6'h27;
   localparam logic [5:0] fnSlt  = 6'h2a;
   localparam logic [5:0] fnSltu = 6'h2b;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
   } aluOpT;

   typedef struct packed {
      logic memToReg;
      logic regWrite;
      logic extType;
      logic aluSrc;
      logic regDst;
      logic jump;
      logic jr;
      logic jal;
      logic jalr;
      logic shift;
   } ctrlT;

   typedef enum logic [1:0] {
      srcIcache = 2'd0,
      srcBios   = 2'd1,
      srcIsr    = 2'd2
   } instrSrcT;

   // top address nibble of each region
   localparam logic [3:0] regionIcache = 4'h1;
   localparam logic [3:0] regionImem   = 4'h2;
   localparam logic [3:0] regionDcache = 4'h3;
   localparam logic [3:0] regionBios   = 4'h4;
   localparam logic [3:0] regionIo     = 4'h8;
   localparam logic [3:0] regionIsr    = 4'hc;

   // memory-mapped performance counters
   localparam logic [31:0] cycleCountAddr   = 32'h8000_0010;
   localparam logic [31:0] instrCountAddr   = 32'h8000_0014;
   localparam logic [31:0] counterResetAddr = 32'h8000_0018;

   // rs field of a cop0 instruction
   localparam logic [4:0] cop0Mf = 5'd0;
   localparam logic [4:0] cop0Mt = 5'd4;

endpackage

//--- logic/mainDecoder.sv
`timescale 1ns/100ps

module mainDecoder import mipsCtrlPkg::*; (
   input  logic       clk,
   input  logic       rstN,
   input  logic       stall,
   input  logic [5:0] opcodeF,
   input  logic [5:0] functF,
   input  logic [4:0] rsF,
   output ctrlT       ctrlF,
   output ctrlT       ctrlE,
   output logic       mfc0,
   output logic       mtc0,
   output logic       delaySlot
);

   logic isBranch;

   always_comb begin
      ctrlF    = '0;
      isBranch = 1'b0;
      mfc0     = 1'b0;
      mtc0     = 1'b0;
      case (opcodeF)
         opRtype: begin
            ctrlF.regWrite = (functF != fnJr);
            ctrlF.regDst   = 1'b1;
            ctrlF.jr       = (functF == fnJr);
            ctrlF.jalr     = (functF == fnJalr);
            // shamt shifts only, variable shifts use rs
            ctrlF.shift    = (functF == fnSll) || (functF == fnSrl) || (functF == fnSra);
         end
         opLb, opLh, opLw, opLbu, opLhu: begin
            ctrlF.memToReg = 1'b1;
            ctrlF.regWrite = 1'b1;
            ctrlF.aluSrc   = 1'b1;
         end
         opSb, opSh, opSw: begin
            ctrlF.memToReg = 1'b1;
            ctrlF.aluSrc   = 1'b1;
         end
         opAddiu, opSlti, opSltiu, opLui: begin
            ctrlF.regWrite = 1'b1;
            ctrlF.aluSrc   = 1'b1;
         end
         opAndi, opOri, opXori: begin
            // logical immediates are zero extended
            ctrlF.regWrite = 1'b1;
            ctrlF.extType  = 1'b1;
            ctrlF.aluSrc   = 1'b1;
         end
         opJ: ctrlF.jump = 1'b1;
         opJal: begin
            ctrlF.regWrite = 1'b1;
            ctrlF.regDst   = 1'b1;
            ctrlF.jump     = 1'b1;
            ctrlF.jal      = 1'b1;
         end
         opBeq, opBne, opBlez, opBgtz, opRegimm: isBranch = 1'b1;
         opCop0: begin
            mfc0           = (rsF == cop0Mf);
            mtc0           = (rsF == cop0Mt);
            ctrlF.regWrite = (rsF == cop0Mf);
         end
         default: ctrlF = '0;
      endcase
   end

   // next instruction sits in a delay slot
   assign delaySlot = isBranch | ctrlF.jump | ctrlF.jr | ctrlF.jalr | mfc0 | mtc0;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         ctrlE <= '0;
      end else if (!stall) begin
         ctrlE <= ctrlF;
      end
   end

   assert property (@(posedge clk) disable iff (!rstN) !(ctrlE.jr && ctrlE.jalr));
   assert property (@(posedge clk) !rstN |=> ctrlE == '0);

endmodule

//--- logic/aluDecoder.sv
`timescale 1ns/100ps

module aluDecoder import mipsCtrlPkg::*; (
   input  logic [5:0] opcodeE,
   input  logic [5:0] functE,
   output aluOpT      aluOp
);

   always_comb begin
      case (opcodeE)
         opRtype: begin
            case (functE)
               fnAddu:        aluOp = aluAdd;
               fnSubu:        aluOp = aluSub;
               fnAnd:         aluOp = aluAnd;
               fnOr:          aluOp = aluOr;
               fnXor:         aluOp = aluXor;
               fnNor:         aluOp = aluNor;
               fnSlt:         aluOp = aluSlt;
               fnSltu:        aluOp = aluSltu;
               // shamt and variable shifts share the shifter
               fnSll, fnSllv: aluOp = aluSll;
               fnSrl, fnSrlv: aluOp = aluSrl;
               fnSra, fnSrav: aluOp = aluSra;
               default:       aluOp = aluAdd;
            endcase
         end
         // address generation
         opLb, opLh, opLw, opLbu, opLhu,
         opSb, opSh, opSw, opAddiu:       aluOp = aluAdd;
         opSlti:                          aluOp = aluSlt;
         opSltiu:                         aluOp = aluSltu;
         opAndi:                          aluOp = aluAnd;
         opOri:                           aluOp = aluOr;
         opXori:                          aluOp = aluXor;
         opLui:                           aluOp = aluLui;
         opBeq, opBne:                    aluOp = aluSub;
         default:                         aluOp = aluAdd;
      endcase
   end

endmodule

//--- logic/branchResolver.sv
`timescale 1ns/100ps

module branchResolver import mipsCtrlPkg::*; (
   input  logic [5:0]  opcodeE,
   input  logic [4:0]  rtE,
   input  logic [31:0] rd1Fwd,
   input  logic [31:0] rd2Fwd,
   output logic        branchTaken
);

   logic isNeg;
   logic isZero;

   // signed tests only need the sign bit and a zero check
   assign isNeg  = rd1Fwd[31];
   assign isZero = (rd1Fwd == 32'd0);

   always_comb begin
      case (opcodeE)
         opBeq:    branchTaken = (rd1Fwd == rd2Fwd);
         opBne:    branchTaken = (rd1Fwd != rd2Fwd);
         opBlez:   branchTaken = isNeg | isZero;
         opBgtz:   branchTaken = !isNeg && !isZero;
         // rt selects bltz (0) or bgez (1)
         opRegimm: branchTaken = (rtE == 5'd0) ? isNeg : ((rtE == 5'd1) && !isNeg);
         default:  branchTaken = 1'b0;
      endcase
   end

endmodule

//--- logic/forwardUnit.sv
`timescale 1ns/100ps

module forwardUnit (
   input  logic [4:0] rsF,
   input  logic [4:0] rtF,
   input  logic [4:0] rsE,
   input  logic [4:0] rtE,
   input  logic [4:0] waM,
   input  logic       regWriteM,
   output logic       fwdAMtoE,
   output logic       fwdBMtoE,
   output logic       fwdAMtoF,
   output logic       fwdBMtoF
);

   logic mValid;

   // $0 is never a real producer
   assign mValid = regWriteM && (waM != 5'd0);

   assign fwdAMtoE = mValid && (waM == rsE);
   assign fwdBMtoE = mValid && (waM == rtE);
   assign fwdAMtoF = mValid && (waM == rsF);
   assign fwdBMtoF = mValid && (waM == rtF);

   always_comb begin
      assert (waM != 5'd0 || !(fwdAMtoE | fwdBMtoE | fwdAMtoF | fwdBMtoF));
   end

endmodule

//--- memCtrl/storeEnableGen.sv
`timescale 1ns/100ps

module storeEnableGen import mipsCtrlPkg::*; (
   input  logic [5:0]  opcodeE,
   input  logic [1:0]  byteOffsetE,
   input  logic [31:0] aluOutE,
   input  logic [31:0] pcE,
   input  logic        stall,
   input  logic        isLoadE,
   output logic [3:0]  dataMemWe,
   output logic [3:0]  instrMemWe,
   output logic [3:0]  isrMemWe
);

   logic [3:0] lanes;
   logic [3:0] region;
   logic       wrOk;

   assign region = aluOutE[31:28];
   assign wrOk   = !stall && !isLoadE;

   // big-endian lanes, byte 0 lives in lane 3
   always_comb begin
      case (opcodeE)
         opSb:    lanes = 4'b1000 >> byteOffsetE;
         opSh:    lanes = byteOffsetE[1] ? 4'b0011 : 4'b1100;
         opSw:    lanes = 4'b1111;
         default: lanes = 4'b0000;
      endcase
   end

   assign dataMemWe = (wrOk && (region == regionIcache || region == regionDcache)) ?
                      lanes : 4'b0000;

   // imem is writable only from code running out of bios
   assign instrMemWe = (wrOk && region == regionImem && pcE[31:28] == regionBios) ?
                       lanes : 4'b0000;

   assign isrMemWe = (wrOk && region == regionIsr) ? lanes : 4'b0000;

   always_comb begin
      assert (!isLoadE || (dataMemWe == 4'b0 && instrMemWe == 4'b0 && isrMemWe == 4'b0));
   end

endmodule

//--- memCtrl/addressMapDecoder.sv
`timescale 1ns/100ps

module addressMapDecoder import mipsCtrlPkg::*; (
   input  logic [5:0]  opcodeE,
   input  logic [31:0] aluOutE,
   input  logic [31:0] pc,
   input  logic [31:0] nextPc,
   output logic        isLoadE,
   output logic        legalReadE,
   output logic        biosDataEn,
   output logic        biosPcEn,
   output instrSrcT    instrSrc,
   output logic        dcacheRe,
   output logic        icacheRe,
   output logic        readCycleCount,
   output logic        readInstrCount,
   output logic        resetCounters
);

   logic [3:0] region;

   assign region  = aluOutE[31:28];
   assign isLoadE = (opcodeE == opLb) || (opcodeE == opLh) || (opcodeE == opLw) ||
                    (opcodeE == opLbu) || (opcodeE == opLhu);

   // fetch source, bios is the fallback
   always_comb begin
      case (pc[31:28])
         regionIcache: instrSrc = srcIcache;
         regionIsr:    instrSrc = srcIsr;
         default:      instrSrc = srcBios;
      endcase
   end

   assign biosPcEn   = (pc[31:28] == regionBios);
   assign biosDataEn = isLoadE && (region == regionBios);
   assign legalReadE = isLoadE && (region == regionIcache || region == regionDcache ||
                                   region == regionBios || region == regionIo);

   // matches regions 1 and 3
   assign dcacheRe = isLoadE && !aluOutE[31] && !aluOutE[30] && aluOutE[28];
   assign icacheRe = (pc[31:28] == regionIcache) || (nextPc[31:28] == regionIcache);

   assign readCycleCount = (aluOutE == cycleCountAddr);
   assign readInstrCount = (aluOutE == instrCountAddr);
   assign resetCounters  = (aluOutE == counterResetAddr);

endmodule

//--- logic/mipsControl.sv
`timescale 1ns/100ps

module mipsControl import mipsCtrlPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic        stall,
   input  logic [5:0]  opcodeF,
   input  logic [5:0]  functF,
   input  logic [4:0]  rsF,
   input  logic [4:0]  rtF,
   input  logic [5:0]  opcodeE,
   input  logic [5:0]  functE,
   input  logic [4:0]  rsE,
   input  logic [4:0]  rtE,
   input  logic [31:0] aluOutE,
   input  logic [1:0]  byteOffsetE,
   input  logic [31:0] rd1Fwd,
   input  logic [31:0] rd2Fwd,
   input  logic [4:0]  waM,
   input  logic        regWriteM,
   input  logic [31:0] pc,
   input  logic [31:0] pcE,
   input  logic [31:0] nextPc,
   output ctrlT        ctrlF,
   output ctrlT        ctrlE,
   output logic        mfc0,
   output logic        mtc0,
   output logic        delaySlot,
   output aluOpT       aluOp,
   output logic        branchTaken,
   output logic        fwdAMtoE,
   output logic        fwdBMtoE,
   output logic        fwdAMtoF,
   output logic        fwdBMtoF,
   output logic [3:0]  dataMemWe,
   output logic [3:0]  instrMemWe,
   output logic [3:0]  isrMemWe,
   output logic        isLoadE,
   output logic        legalReadE,
   output logic        biosDataEn,
   output logic        biosPcEn,
   output instrSrcT    instrSrc,
   output logic        dcacheRe,
   output logic        icacheRe,
   output logic        readCycleCount,
   output logic        readInstrCount,
   output logic        resetCounters
);

   mainDecoder u_mainDecoder (
      .clk(clk), .rstN(rstN), .stall(stall),
      .opcodeF(opcodeF), .functF(functF), .rsF(rsF),
      .ctrlF(ctrlF), .ctrlE(ctrlE),
      .mfc0(mfc0), .mtc0(mtc0), .delaySlot(delaySlot)
   );

   aluDecoder u_aluDecoder (.opcodeE(opcodeE), .functE(functE), .aluOp(aluOp));

   branchResolver u_branchResolver (
      .opcodeE(opcodeE), .rtE(rtE), .rd1Fwd(rd1Fwd), .rd2Fwd(rd2Fwd),
      .branchTaken(branchTaken)
   );

   forwardUnit u_forwardUnit (
      .rsF(rsF), .rtF(rtF), .rsE(rsE), .rtE(rtE), .waM(waM), .regWriteM(regWriteM),
      .fwdAMtoE(fwdAMtoE), .fwdBMtoE(fwdBMtoE), .fwdAMtoF(fwdAMtoF), .fwdBMtoF(fwdBMtoF)
   );

   // isLoadE comes from the address map
   storeEnableGen u_storeEnableGen (
      .opcodeE(opcodeE), .byteOffsetE(byteOffsetE), .aluOutE(aluOutE), .pcE(pcE),
      .stall(stall), .isLoadE(isLoadE),
      .dataMemWe(dataMemWe), .instrMemWe(instrMemWe), .isrMemWe(isrMemWe)
   );

   addressMapDecoder u_addressMapDecoder (
      .opcodeE(opcodeE), .aluOutE(aluOutE), .pc(pc), .nextPc(nextPc),
      .isLoadE(isLoadE), .legalReadE(legalReadE),
      .biosDataEn(biosDataEn), .biosPcEn(biosPcEn), .instrSrc(instrSrc),
      .dcacheRe(dcacheRe), .icacheRe(icacheRe),
      .readCycleCount(readCycleCount), .readInstrCount(readInstrCount),
      .resetCounters(resetCounters)
   );

endmodule

//--- tests/tbMipsControl.sv
`timescale 1ns/100ps

module tbMipsControl import mipsCtrlPkg::*; ();

   logic        clk = 1'b0;
   logic        rstN;
   logic        stall;
   logic [5:0]  opcodeF;
   logic [5:0]  functF;
   logic [4:0]  rsF;
   logic [4:0]  rtF;
   logic [5:0]  opcodeE;
   logic [5:0]  functE;
   logic [4:0]  rsE;
   logic [4:0]  rtE;
   logic [31:0] aluOutE;
   logic [1:0]  byteOffsetE;
   logic [31:0] rd1Fwd;
   logic [31:0] rd2Fwd;
   logic [4:0]  waM;
   logic        regWriteM;
   logic [31:0] pc;
   logic [31:0] pcE;
   logic [31:0] nextPc;
   ctrlT        ctrlF;
   ctrlT        ctrlE;
   logic        mfc0;
   logic        mtc0;
   logic        delaySlot;
   aluOpT       aluOp;
   logic        branchTaken;
   logic        fwdAMtoE;
   logic        fwdBMtoE;
   logic        fwdAMtoF;
   logic        fwdBMtoF;
   logic [3:0]  dataMemWe;
   logic [3:0]  instrMemWe;
   logic [3:0]  isrMemWe;
   logic        isLoadE;
   logic        legalReadE;
   logic        biosDataEn;
   logic        biosPcEn;
   instrSrcT    instrSrc;
   logic        dcacheRe;
   logic        icacheRe;
   logic        readCycleCount;
   logic        readInstrCount;
   logic        resetCounters;

   int          errors;
   int          testsPassed;
   int          testsFailed;
   logic [31:0] seed;

   mipsControl u_dut (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check(input logic ok, input string what);
      assert (ok) else begin
         $display("[FAIL] %0t ns: %s", $time, what);
         errors++;
      end
   endtask

   task automatic endTest(input string name, input int errsBefore);
      if (errors == errsBefore) begin
         testsPassed++;
         $display("%s: ok", name);
      end else begin
         testsFailed++;
         $display("%s: %0d errors", name, errors - errsBefore);
      end
   endtask

   task automatic waitFalling(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
      end
   endtask

   task automatic decodeCase(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rs,
                             input logic [9:0] wantCtrl, input logic [2:0] wantFlags);
      @(negedge clk);
      opcodeF = op;
      functF = fn;
      rsF = rs;
      #1;
      check(ctrlF == wantCtrl, $sformatf("decode op %h fn %h rs %0d: ctrlF %b, expected %b",
                                         op, fn, rs, ctrlF, wantCtrl));
      check({mfc0, mtc0, delaySlot} == wantFlags,
            $sformatf("decode op %h fn %h rs %0d: flags %b, expected %b",
                      op, fn, rs, {mfc0, mtc0, delaySlot}, wantFlags));
   endtask

   task automatic mainDecodeTest();
      logic [5:0] loads [5] = '{opLb, opLh, opLw, opLbu, opLhu};
      logic [5:0] stores [3] = '{opSb, opSh, opSw};
      logic [5:0] immArith [4] = '{opAddiu, opSlti, opSltiu, opLui};
      logic [5:0] immLogic [3] = '{opAndi, opOri, opXori};
      logic [5:0] branches [5] = '{opBeq, opBne, opBlez, opBgtz, opRegimm};
      int e0;
      e0 = errors;
      #1;
      check(ctrlE == '0, "ctrlE not cleared by reset");
      // ctrl bits are memToReg regWrite extType aluSrc regDst jump jr jal jalr shift
      // flag bits are mfc0 mtc0 delaySlot
      decodeCase(opRtype, fnAddu, 5'd0, 10'b0100100000, 3'b000);
      decodeCase(opRtype, fnSllv, 5'd0, 10'b0100100000, 3'b000);
      decodeCase(opRtype, fnSll, 5'd0, 10'b0100100001, 3'b000);
      decodeCase(opRtype, fnSrl, 5'd0, 10'b0100100001, 3'b000);
      decodeCase(opRtype, fnSra, 5'd0, 10'b0100100001, 3'b000);
      decodeCase(opRtype, fnJr, 5'd0, 10'b0000101000, 3'b001);
      decodeCase(opRtype, fnJalr, 5'd0, 10'b0100100010, 3'b001);
      foreach (loads[i]) decodeCase(loads[i], 6'd0, 5'd0, 10'b1101000000, 3'b000);
      foreach (stores[i]) decodeCase(stores[i], 6'd0, 5'd0, 10'b1001000000, 3'b000);
      foreach (immArith[i]) decodeCase(immArith[i], 6'd0, 5'd0, 10'b0101000000, 3'b000);
      foreach (immLogic[i]) decodeCase(immLogic[i], 6'd0, 5'd0, 10'b0111000000, 3'b000);
      decodeCase(opJ, 6'd0, 5'd0, 10'b0000010000, 3'b001);
      decodeCase(opJal, 6'd0, 5'd0, 10'b0100110100, 3'b001);
      foreach (branches[i]) decodeCase(branches[i], 6'd0, 5'd0, 10'b0000000000, 3'b001);
      decodeCase(opCop0, 6'd0, cop0Mf, 10'b0100000000, 3'b101);
      decodeCase(opCop0, 6'd0, cop0Mt, 10'b0000000000, 3'b011);
      decodeCase(6'h3f, 6'd0, 5'd0, 10'b0000000000, 3'b000);
      // execute register follows after one edge, then freezes on stall
      @(negedge clk);
      opcodeF = opLw;
      @(negedge clk);
      check(ctrlE == 10'b1101000000, "ctrlE did not follow ctrlF after one edge");
      stall = 1'b1;
      opcodeF = opJ;
      waitFalling(2);
      check(ctrlE == 10'b1101000000, "ctrlE changed during stall");
      stall = 1'b0;
      waitFalling(1);
      check(ctrlE == 10'b0000010000, "ctrlE did not load after stall released");
      endTest("main decode", e0);
   endtask

   task automatic aluCase(input logic [5:0] op, input logic [5:0] fn, input aluOpT want);
      @(negedge clk);
      opcodeE = op;
      functE = fn;
      #1;
      check(aluOp == want, $sformatf("alu op %h fn %h: got %s, expected %s",
                                     op, fn, aluOp.name(), want.name()));
   endtask

   task automatic aluDecodeTest();
      logic [5:0] addOps [9] = '{opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw, opAddiu};
      int e0;
      e0 = errors;
      aluCase(opRtype, fnAddu, aluAdd);
      aluCase(opRtype, fnSubu, aluSub);
      aluCase(opRtype, fnAnd, aluAnd);
      aluCase(opRtype, fnOr, aluOr);
      aluCase(opRtype, fnXor, aluXor);
      aluCase(opRtype, fnNor, aluNor);
      aluCase(opRtype, fnSlt, aluSlt);
      aluCase(opRtype, fnSltu, aluSltu);
      aluCase(opRtype, fnSll, aluSll);
      aluCase(opRtype, fnSllv, aluSll);
      aluCase(opRtype, fnSrl, aluSrl);
      aluCase(opRtype, fnSrlv, aluSrl);
      aluCase(opRtype, fnSra, aluSra);
      aluCase(opRtype, fnSrav, aluSra);
      aluCase(opRtype, 6'h3e, aluAdd);
      foreach (addOps[i]) aluCase(addOps[i], 6'd0, aluAdd);
      aluCase(opSlti, 6'd0, aluSlt);
      aluCase(opSltiu, 6'd0, aluSltu);
      aluCase(opAndi, 6'd0, aluAnd);
      aluCase(opOri, 6'd0, aluOr);
      aluCase(opXori, 6'd0, aluXor);
      aluCase(opLui, 6'd0, aluLui);
      aluCase(opBeq, 6'd0, aluSub);
      aluCase(opBne, 6'd0, aluSub);
      aluCase(6'h3f, 6'd0, aluAdd);
      endTest("alu decode", e0);
   endtask

   // signed branch conditions
   function automatic logic branchRule(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [31:0] a, input logic [31:0] b);
      case (op)
         opBeq:    return a == b;
         opBne:    return a != b;
         opBlez:   return $signed(a) <= 0;
         opBgtz:   return $signed(a) > 0;
         opRegimm: return (rt == 5'd0) ? ($signed(a) < 0) : ($signed(a) >= 0);
         default:  return 1'b0;
      endcase
   endfunction

   task automatic branchCase(input logic [5:0] op, input logic [4:0] rt,
                             input logic [31:0] a, input logic [31:0] b);
      @(negedge clk);
      opcodeE = op;
      rtE = rt;
      rd1Fwd = a;
      rd2Fwd = b;
      #1;
      check(branchTaken == branchRule(op, rt, a, b),
            $sformatf("branch op %h rt %0d a %h b %h: taken %b", op, rt, a, b, branchTaken));
   endtask

   task automatic branchTest();
      logic [5:0]  ops [6] = '{opBeq, opBne, opBlez, opBgtz, opRegimm, opRegimm};
      logic [4:0]  rts [6] = '{5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd1};
      logic [31:0] a;
      int e0;
      e0 = errors;
      for (int t = 0; t < 6; t++) begin
         for (int i = 0; i < 40; i++) begin
            a = nextRand();
            branchCase(ops[t], rts[t], a, nextRand());
         end
         // equal, zero and negative corners
         a = nextRand();
         branchCase(ops[t], rts[t], a, a);
         branchCase(ops[t], rts[t], 32'd0, 32'd0);
         branchCase(ops[t], rts[t], 32'd0, a);
         branchCase(ops[t], rts[t], 32'h8000_0000, 32'd1);
         branchCase(ops[t], rts[t], 32'hffff_ffff, 32'hffff_ffff);
         branchCase(ops[t], rts[t], 32'h7fff_ffff, 32'd0);
      end
      endTest("branches", e0);
   endtask

   task automatic fwdCase(input logic [4:0] sF, input logic [4:0] tF, input logic [4:0] sE,
                          input logic [4:0] tE, input logic [4:0] wa, input logic we);
      logic [4:0] srcs [4];
      logic [3:0] want;
      @(negedge clk);
      rsF = sF;
      rtF = tF;
      rsE = sE;
      rtE = tE;
      waM = wa;
      regWriteM = we;
      #1;
      // one select per source register in port order
      srcs = '{sE, tE, sF, tF};
      want = 4'b0000;
      foreach (srcs[k]) begin
         if (we && wa != 5'd0 && srcs[k] == wa) begin
            want[3 - k] = 1'b1;
         end
      end
      check({fwdAMtoE, fwdBMtoE, fwdAMtoF, fwdBMtoF} == want,
            $sformatf("forward wa %0d we %b rs/rt F %0d/%0d E %0d/%0d: got %b, expected %b",
                      wa, we, sF, tF, sE, tE,
                      {fwdAMtoE, fwdBMtoE, fwdAMtoF, fwdBMtoF}, want));
   endtask

   task automatic forwardingTest();
      logic [31:0] r;
      logic [4:0]  src [4];
      int e0;
      e0 = errors;
      for (int i = 0; i < 60; i++) begin
         r = nextRand();
         for (int k = 0; k < 4; k++) begin
            src[k] = r[5*k +: 5];
         end
         // about half the time one source hits the write address
         if (r[27]) begin
            src[r[26:25]] = r[24:20];
         end
         fwdCase(src[0], src[1], src[2], src[3], r[24:20], r[28] | r[29]);
      end
      fwdCase(5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1);
      fwdCase(5'd7, 5'd7, 5'd7, 5'd7, 5'd7, 1'b0);
      endTest("forwarding", e0);
   endtask

   task automatic storeCase(input logic [5:0] op, input logic [1:0] off, input logic [31:0] addr,
                            input logic [31:0] pcIn, input logic stl, input logic [3:0] wantData,
                            input logic [3:0] wantInstr, input logic [3:0] wantIsr);
      @(negedge clk);
      opcodeE = op;
      byteOffsetE = off;
      aluOutE = addr;
      pcE = pcIn;
      stall = stl;
      #1;
      check({dataMemWe, instrMemWe, isrMemWe} == {wantData, wantInstr, wantIsr},
            $sformatf("store op %h addr %h pcE %h stall %b: we %b/%b/%b, expected %b/%b/%b",
                      op, addr, pcIn, stl, dataMemWe, instrMemWe, isrMemWe,
                      wantData, wantInstr, wantIsr));
   endtask

   task automatic storeTest();
      logic [31:0] pcBios;
      int e0;
      pcBios = 32'h4000_0040;
      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         storeCase(opSb, 2'(i), 32'h1000_0100 + i, pcBios, 1'b0, 4'b0001 << (3 - i),
                   4'b0, 4'b0);
      end
      storeCase(opSh, 2'd0, 32'h3000_0200, pcBios, 1'b0, 4'b1100, 4'b0, 4'b0);
      storeCase(opSh, 2'd2, 32'h3000_0202, pcBios, 1'b0, 4'b0011, 4'b0, 4'b0);
      storeCase(opSw, 2'd0, 32'h1000_0300, pcBios, 1'b0, 4'b1111, 4'b0, 4'b0);
      storeCase(opSw, 2'd0, 32'h3000_0300, pcBios, 1'b0, 4'b1111, 4'b0, 4'b0);
      storeCase(opSw, 2'd0, 32'h2000_0400, pcBios, 1'b0, 4'b0, 4'b1111, 4'b0);
      // imem write from outside bios is dropped
      storeCase(opSw, 2'd0, 32'h2000_0400, 32'h1000_0000, 1'b0, 4'b0, 4'b0, 4'b0);
      storeCase(opSw, 2'd0, 32'hc000_0500, pcBios, 1'b0, 4'b0, 4'b0, 4'b1111);
      storeCase(opSb, 2'd1, 32'hc000_0501, pcBios, 1'b0, 4'b0, 4'b0, 4'b0100);
      storeCase(opSw, 2'd0, 32'h8000_0000, pcBios, 1'b0, 4'b0, 4'b0, 4'b0);
      storeCase(opSw, 2'd0, 32'h1000_0300, pcBios, 1'b1, 4'b0, 4'b0, 4'b0);
      storeCase(opLw, 2'd0, 32'h1000_0300, pcBios, 1'b0, 4'b0, 4'b0, 4'b0);
      storeCase(opLbu, 2'd0, 32'hc000_0500, pcBios, 1'b0, 4'b0, 4'b0, 4'b0);
      stall = 1'b0;
      endTest("stores", e0);
   endtask

   task automatic addrCase(input logic [5:0] op, input logic [31:0] addr,
                           input logic [31:0] pcIn, input logic [31:0] npc);
      logic       ld;
      logic [3:0] rg;
      instrSrcT   src;
      string      msg;
      @(negedge clk);
      opcodeE = op;
      aluOutE = addr;
      pc = pcIn;
      nextPc = npc;
      #1;
      ld = op inside {opLb, opLh, opLw, opLbu, opLhu};
      rg = addr[31:28];
      src = (pcIn[31:28] == 4'h1) ? srcIcache : (pcIn[31:28] == 4'hc) ? srcIsr : srcBios;
      msg = $sformatf("map op %h addr %h pc %h nextPc %h", op, addr, pcIn, npc);
      check(isLoadE == ld, {msg, ": isLoadE wrong"});
      check(legalReadE == (ld && rg inside {4'h1, 4'h3, 4'h4, 4'h8}),
            {msg, ": legalReadE wrong"});
      check(biosDataEn == (ld && rg == 4'h4), {msg, ": biosDataEn wrong"});
      check(biosPcEn == (pcIn[31:28] == 4'h4), {msg, ": biosPcEn wrong"});
      check(instrSrc == src, {msg, ": instrSrc wrong"});
      check(dcacheRe == (ld && addr[31:30] == 2'b00 && addr[28]), {msg, ": dcacheRe wrong"});
      check(icacheRe == (pcIn[31:28] == 4'h1 || npc[31:28] == 4'h1),
            {msg, ": icacheRe wrong"});
      check({readCycleCount, readInstrCount, resetCounters} ==
            {addr == 32'h8000_0010, addr == 32'h8000_0014, addr == 32'h8000_0018},
            {msg, ": counter strobes wrong"});
   endtask

   task automatic addressMapTest();
      logic [3:0]  regions [9] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h8, 4'hc, 4'hf};
      logic [5:0]  ops [4] = '{opLw, opLbu, opSw, opAddiu};
      logic [31:0] r;
      int e0;
      e0 = errors;
      for (int i = 0; i < 9; i++) begin
         for (int k = 0; k < 4; k++) begin
            r = nextRand();
            addrCase(ops[k], {regions[(i + k) % 9], r[27:0]}, {regions[i], r[27:2], 2'b00},
                     {regions[(i + 3) % 9], 28'h0});
         end
      end
      addrCase(opLw, 32'h8000_0010, 32'h4000_0000, 32'h4000_0004);
      addrCase(opLw, 32'h8000_0014, 32'h4000_0000, 32'h4000_0004);
      addrCase(opSw, 32'h8000_0018, 32'h1000_0000, 32'h1000_0004);
      addrCase(opLw, 32'h8000_001c, 32'hc000_0000, 32'hc000_0004);
      endTest("address map", e0);
   endtask

   // watchdog on the whole run
   initial begin
      for (int c = 0; c < 5000; c++) begin
         @(posedge clk);
      end
      $display("timeout: run did not finish within 5000 clock cycles");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      rstN = 1'b0;
      stall = 1'b0;
      opcodeF = '0;
      functF = '0;
      rsF = '0;
      rtF = '0;
      opcodeE = '0;
      functE = '0;
      rsE = '0;
      rtE = '0;
      aluOutE = '0;
      byteOffsetE = '0;
      rd1Fwd = '0;
      rd2Fwd = '0;
      waM = '0;
      regWriteM = 1'b0;
      pc = '0;
      pcE = '0;
      nextPc = '0;
      seed = 32'h1d0ad258;
      errors = 0;
      testsPassed = 0;
      testsFailed = 0;
      waitFalling(10);
      rstN = 1'b1;
      mainDecodeTest();
      aluDecodeTest();
      branchTest();
      forwardingTest();
      storeTest();
      addressMapTest();
      $display("summary: %0d run, %0d ok, %0d with errors, %0d failed checks",
               testsPassed + testsFailed, testsPassed, testsFailed, errors);
      if (testsFailed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- mipsControl.f
common/mipsCtrlPkg.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/branchResolver.sv
logic/forwardUnit.sv
memCtrl/storeEnableGen.sv
memCtrl/addressMapDecoder.sv
logic/mipsControl.sv
tests/tbMipsControl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsControl
RTL_TOP   ?= mipsControl
FILELIST  ?= mipsControl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only --timing -Wall -Wno-fatal --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
